//--- project.f
rtl/uart_pkg.sv
rtl/uart_ctrl.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_wb_top.sv
dv/tb_clock_gen.sv
dv/tb_uart_wb.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --timescale 1ns/10ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/10ps
TOP        := tb_uart_wb
FILELIST   := project.f
OBJ_DIR    := obj_dir
PASS_MSG   := Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The verdict comes from the simulation output, no log is kept
sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_uart_wb.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart_wb;

    localparam uart_pkg::word_t BASE = 32'h2000_0000;
    localparam int DIV_VAL   = 4;
    localparam int BIT_CYC   = DIV_VAL + 2;
    localparam int TX_BYTES  = 4;
    localparam int RX_BYTES  = 4;
    localparam int FRAME_CYC = 10 * BIT_CYC;
    localparam int GUARD_CYC = uart_pkg::GUARD_BITS * BIT_CYC;
    localparam int ACK_LIMIT = 2 * GUARD_CYC + 2 * FRAME_CYC;
    localparam int UNMAPPED_WAIT = 16;
    // All frames plus up to three guard periods, doubled
    localparam int FRAMES       = TX_BYTES + 2 + RX_BYTES + 1;
    localparam int WATCHDOG_CYC = 2 * (FRAMES * FRAME_CYC + 3 * GUARD_CYC) + 500;

    logic clk, resetn;
    uart_pkg::word_t wb_adr_i, wb_dat_i, wb_dat_o;
    logic [3:0] wb_sel_i;
    logic wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
    logic ser_tx_o, ser_rx_i, uart_enabled_o;

    logic [23:0] lfsr;
    string cur_test;
    int errors, test_err_start, tests_run, tests_failed;

    tb_clock_gen u_clk (.clk_o(clk), .resetn_o(resetn));

    uart_wb_top UUT (
        .clk(clk), .resetn(resetn),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
        .ser_tx_o(ser_tx_o), .ser_rx_i(ser_rx_i), .uart_enabled_o(uart_enabled_o)
    );

    // 24-bit Fibonacci LFSR, taps 24 23 22 17
    function automatic logic [23:0] lfsr_step(input logic [23:0] s);
        return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
    endfunction

    function automatic uart_pkg::byte_t rand_byte();
        uart_pkg::byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    task automatic check_word(input string what, input uart_pkg::word_t exp,
                              input uart_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
                     cur_test, what, exp, act);
        end
    endtask

    task automatic check_byte(input string what, input uart_pkg::byte_t exp,
                              input uart_pkg::byte_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s, %s: expected 0x%02h, actual 0x%02h",
                     cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    // Starts and ends on a falling edge, ack sampled 1 ns after the drive
    task automatic bus_access(input uart_pkg::word_t adr, input uart_pkg::word_t wdat,
                              input logic [3:0] sel, input logic we, input int max_cycles,
                              output uart_pkg::word_t rdat, output logic acked,
                              output int waited);
        acked    = 1'b0;
        rdat     = '0;
        waited   = 0;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = sel;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        while (!acked && waited < max_cycles) begin
            #1;
            if (wb_ack_o) begin
                acked = 1'b1;
                rdat  = wb_dat_o;
                @(posedge clk);  // Transfer completes here
            end else begin
                waited++;
            end
            @(negedge clk);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input uart_pkg::word_t adr, input uart_pkg::word_t wdat,
                             input logic [3:0] sel, output int waited);
        uart_pkg::word_t unused;
        logic acked;
        bus_access(adr, wdat, sel, 1'b1, ACK_LIMIT, unused, acked, waited);
        if (!acked) begin
            errors++;
            $display("Error in %s: write to 0x%08h got no acknowledge", cur_test, adr);
        end
    endtask

    task automatic bus_read(input uart_pkg::word_t adr, output uart_pkg::word_t rdat);
        logic acked;
        int waited;
        bus_access(adr, '0, 4'hF, 1'b0, ACK_LIMIT, rdat, acked, waited);
        if (!acked) begin
            errors++;
            $display("Error in %s: read of 0x%08h got no acknowledge", cur_test, adr);
        end
    endtask

    // Serial driver for ser_rx
    task automatic send_frame(input uart_pkg::byte_t data, input int bit_cyc);
        ser_rx_i = 1'b0;
        repeat (bit_cyc) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            ser_rx_i = data[i];
            repeat (bit_cyc) @(negedge clk);
        end
        ser_rx_i = 1'b1;
        repeat (bit_cyc) @(negedge clk);
    endtask

    // Monitor, samples ser_tx in the middle of each bit
    task automatic capture_frame(output uart_pkg::byte_t data, output logic start_b,
                                 output logic stop_b, output logic seen);
        int polls;
        polls   = 0;
        data    = '0;
        start_b = 1'b1;
        stop_b  = 1'b0;
        while (ser_tx_o !== 1'b0 && polls < ACK_LIMIT) begin
            @(negedge clk);
            polls++;
        end
        seen = (ser_tx_o === 1'b0);
        if (!seen) begin
            errors++;
            $display("Error in %s: no start bit on ser_tx within %0d cycles",
                     cur_test, ACK_LIMIT);
        end else begin
            repeat (BIT_CYC / 2) @(negedge clk);
            start_b = ser_tx_o;
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYC) @(negedge clk);
                data[i] = ser_tx_o;
            end
            repeat (BIT_CYC) @(negedge clk);
            stop_b = ser_tx_o;
        end
    endtask

    task automatic verify_frame(input uart_pkg::byte_t exp, input uart_pkg::byte_t got,
                                input logic start_b, input logic stop_b, input logic seen);
        if (seen) begin
            check_bit("start bit", 1'b0, start_b);
            check_byte("frame data", exp, got);
            check_bit("stop bit", 1'b1, stop_b);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        int errs;
        errs = errors - test_err_start;
        tests_run++;
        if (errs == 0) begin
            $display("Test %-14s passed", cur_test);
        end else begin
            tests_failed++;
            $display("Test %-14s failed with %0d errors", cur_test, errs);
        end
    endtask

    task automatic test_reset_state();
        uart_pkg::word_t d;
        begin_test("reset_state");
        check_bit("ser_tx_o idle", 1'b1, ser_tx_o);
        check_bit("uart_enabled_o", 1'b0, uart_enabled_o);
        bus_read(BASE | uart_pkg::DIV_OFS, d);
        check_word("divider", 32'd1, d);
        bus_read(BASE | uart_pkg::CFG_OFS, d);
        check_word("config", 32'd0, d);
        bus_read(BASE | uart_pkg::DAT_OFS, d);
        check_word("data", 32'hFFFF_FFFF, d);
        end_test();
    endtask

    task automatic test_divider_lanes();
        uart_pkg::word_t d, wdat, mask;
        int w;
        begin_test("divider_lanes");
        wdat = 32'h1122_3344;
        mask = 32'h00FF_00FF;  // Lanes 0 and 2
        bus_write(BASE | uart_pkg::DIV_OFS, wdat, 4'b0101, w);
        bus_read(BASE | uart_pkg::DIV_OFS, d);
        check_word("partial divider", (32'd1 & ~mask) | (wdat & mask), d);
        bus_write(BASE | uart_pkg::DIV_OFS, DIV_VAL, 4'b1111, w);
        bus_read(BASE | uart_pkg::DIV_OFS, d);
        check_word("full divider", DIV_VAL, d);
        end_test();
    endtask

    task automatic test_transmit();
        uart_pkg::word_t d;
        uart_pkg::byte_t b, got;
        logic start_b, stop_b, seen;
        int w;
        begin_test("transmit");
        bus_write(BASE | uart_pkg::CFG_OFS, 32'd1, 4'b0001, w);
        check_bit("uart_enabled_o", 1'b1, uart_enabled_o);
        bus_read(BASE | uart_pkg::CFG_OFS, d);
        check_word("config", 32'd1, d);
        bus_write(BASE | uart_pkg::DIV_OFS, DIV_VAL, 4'b1111, w);  // Restarts the guard
        for (int i = 0; i < TX_BYTES; i++) begin
            b = rand_byte();
            fork
                capture_frame(got, start_b, stop_b, seen);
                bus_write(BASE | uart_pkg::DAT_OFS, {24'd0, b}, 4'b0001, w);
            join
            if (i == 0)
                check_bit("first write held for guard", 1'b1, w >= GUARD_CYC);
            verify_frame(b, got, start_b, stop_b, seen);
        end
        end_test();
    endtask

    task automatic test_back_pressure();
        uart_pkg::byte_t b0, b1, got0, got1;
        logic s0, p0, seen0, s1, p1, seen1;
        int w0, w1;
        begin_test("back_pressure");
        b0 = rand_byte();
        b1 = rand_byte();
        fork
            begin
                capture_frame(got0, s0, p0, seen0);
                capture_frame(got1, s1, p1, seen1);
            end
            begin
                bus_write(BASE | uart_pkg::DAT_OFS, {24'd0, b0}, 4'b0001, w0);
                bus_write(BASE | uart_pkg::DAT_OFS, {24'd0, b1}, 4'b0001, w1);
            end
        join
        check_bit("second ack after stop bit", 1'b1, w1 >= FRAME_CYC);
        verify_frame(b0, got0, s0, p0, seen0);
        verify_frame(b1, got1, s1, p1, seen1);
        end_test();
    endtask

    task automatic test_receive();
        uart_pkg::word_t d;
        uart_pkg::byte_t b;
        int w;
        begin_test("receive");
        for (int i = 0; i < RX_BYTES; i++) begin
            b = rand_byte();
            send_frame(b, BIT_CYC);
            bus_read(BASE | uart_pkg::DAT_OFS, d);
            check_word("received byte", {24'd0, b}, d);
            bus_read(BASE | uart_pkg::DAT_OFS, d);
            check_word("second read", 32'hFFFF_FFFF, d);
        end
        bus_write(BASE | uart_pkg::CFG_OFS, 32'd0, 4'b0001, w);
        check_bit("uart_enabled_o", 1'b0, uart_enabled_o);
        send_frame(rand_byte(), BIT_CYC);
        bus_read(BASE | uart_pkg::DAT_OFS, d);
        check_word("data while disabled", 32'hFFFF_FFFF, d);
        end_test();
    endtask

    task automatic test_unmapped();
        uart_pkg::word_t d;
        logic acked;
        int w;
        begin_test("unmapped");
        for (int k = 0; k < 2; k++) begin
            bus_access(BASE | 32'h0C, '0, 4'hF, k[0], UNMAPPED_WAIT, d, acked, w);
            if (acked) begin
                errors++;
                $display("Error in %s: access to unmapped address 0x%08h was acknowledged",
                         cur_test, BASE | 32'h0C);
            end else begin
                $display("Unmapped 0x%08h: no acknowledge within %0d cycles",
                         BASE | 32'h0C, UNMAPPED_WAIT);
            end
        end
        end_test();
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        ser_rx_i = 1'b1;  // Line idle
        lfsr     = 24'd91988;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        @(posedge resetn);
        @(negedge clk);
        test_reset_state();
        test_divider_lanes();
        test_transmit();
        test_back_pressure();
        test_receive();
        test_unmapped();
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic resetn_o
);

    initial begin
        clk_o    = 1'b0;
        resetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        resetn_o = 1'b1;  // Released away from the active edge
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- rtl/uart_wb_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_wb_top #(
    parameter uart_pkg::word_t BASE_ADR = 32'h2000_0000
) (
    input  wire logic            clk,
    input  wire logic            resetn,

    input  wire uart_pkg::word_t wb_adr_i,
    input  wire uart_pkg::word_t wb_dat_i,
    input  wire logic [3:0]      wb_sel_i,
    input  wire logic            wb_we_i,
    input  wire logic            wb_cyc_i,
    input  wire logic            wb_stb_i,
    output logic                 wb_ack_o,
    output uart_pkg::word_t      wb_dat_o,

    output logic                 ser_tx_o,
    input  wire logic            ser_rx_i,
    output logic                 uart_enabled_o
);

    uart_pkg::word_t divider;
    logic            enable;
    logic            div_changed;
    logic            tx_start;
    uart_pkg::byte_t tx_data;
    logic            tx_busy;
    logic            rx_read;
    logic            rx_valid;
    uart_pkg::byte_t rx_data;

    assign uart_enabled_o = enable;

    uart_ctrl #(
        .BASE_ADR (BASE_ADR)
    ) u_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_we_i       (wb_we_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .tx_busy_i     (tx_busy),
        .rx_valid_i    (rx_valid),
        .rx_data_i     (rx_data),
        .divider_o     (divider),
        .enable_o      (enable),
        .div_changed_o (div_changed),
        .tx_start_o    (tx_start),
        .tx_data_o     (tx_data),
        .rx_read_o     (rx_read)
    );

    uart_tx u_tx (
        .clk           (clk),
        .resetn        (resetn),
        .divider_i     (divider),
        .enable_i      (enable),
        .div_changed_i (div_changed),
        .tx_start_i    (tx_start),
        .tx_data_i     (tx_data),
        .tx_busy_o     (tx_busy),
        .ser_tx_o      (ser_tx_o)
    );

    uart_rx u_rx (
        .clk        (clk),
        .resetn     (resetn),
        .divider_i  (divider),
        .enable_i   (enable),
        .rx_read_i  (rx_read),
        .ser_rx_i   (ser_rx_i),
        .rx_valid_o (rx_valid),
        .rx_data_o  (rx_data)
    );

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire uart_pkg::word_t divider_i,
    input  wire logic            enable_i,
    input  wire logic            rx_read_i,
    input  wire logic            ser_rx_i,
    output logic                 rx_valid_o,
    output uart_pkg::byte_t      rx_data_o
);

    uart_pkg::rx_state_e state;
    uart_pkg::word_t     div_cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shift;
    logic                half_bit;
    logic                full_bit;
    logic                sample;
    logic                load;

    // Compare with one extra bit so large dividers do not wrap
    assign half_bit = ({div_cnt, 1'b0} > {1'b0, divider_i});
    assign full_bit = (div_cnt > divider_i);

    assign sample = (state == uart_pkg::RX_DATA) && full_bit;
    assign load   = (state == uart_pkg::RX_STOP) && full_bit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= uart_pkg::RX_IDLE;
            div_cnt    <= '0;
            bit_idx    <= 3'd0;
            rx_valid_o <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (rx_read_i)
                rx_valid_o <= 1'b0;

            case (state)
                uart_pkg::RX_IDLE: begin
                    div_cnt <= '0;
                    if (!ser_rx_i && enable_i)
                        state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START: begin
                    if (half_bit) begin
                        state   <= uart_pkg::RX_DATA;
                        div_cnt <= '0;
                        bit_idx <= 3'd0;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (full_bit) begin
                        div_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= uart_pkg::RX_STOP;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (full_bit) begin
                        rx_valid_o <= 1'b1;  // Wins over a read in the same cycle
                        state      <= uart_pkg::RX_IDLE;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (sample)
            shift <= {ser_rx_i, shift[7:1]};
        if (load)
            rx_data_o <= shift;  // Overwrites an unread byte
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire uart_pkg::word_t divider_i,
    input  wire logic            enable_i,
    input  wire logic            div_changed_i,
    input  wire logic            tx_start_i,
    input  wire uart_pkg::byte_t tx_data_i,
    output logic                 tx_busy_o,
    output logic                 ser_tx_o
);

    logic [9:0]      pattern;   // Bit 0 is on the line
    logic [3:0]      bit_cnt;
    uart_pkg::word_t div_cnt;
    logic            guard_pend;
    logic            idle;

    assign idle      = (bit_cnt == 4'd0);
    assign tx_busy_o = !idle || guard_pend;
    assign ser_tx_o  = pattern[0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pattern    <= '1;
            bit_cnt    <= 4'd0;
            div_cnt    <= '0;
            guard_pend <= 1'b1;  // Guard period after reset
        end else begin
            div_cnt <= div_cnt + 1'b1;

            if (guard_pend && idle) begin
                // Line stays high for the whole guard period
                pattern    <= '1;
                bit_cnt    <= 4'(uart_pkg::GUARD_BITS);
                div_cnt    <= '0;
                guard_pend <= 1'b0;
            end else if (tx_start_i && idle) begin
                pattern <= {1'b1, tx_data_i, 1'b0};  // Stop, data, start
                bit_cnt <= 4'd10;
                div_cnt <= '0;
            end else if (!idle && div_cnt > divider_i) begin
                pattern <= {1'b1, pattern[9:1]};
                bit_cnt <= bit_cnt - 1'b1;
                div_cnt <= '0;
            end

            // New divider while running, restart the guard
            if (div_changed_i && enable_i)
                guard_pend <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module uart_ctrl #(
    parameter uart_pkg::word_t BASE_ADR = 32'h2000_0000
) (
    input  wire logic            clk,
    input  wire logic            resetn,

    input  wire uart_pkg::word_t wb_adr_i,
    input  wire uart_pkg::word_t wb_dat_i,
    input  wire logic [3:0]      wb_sel_i,
    input  wire logic            wb_we_i,
    input  wire logic            wb_cyc_i,
    input  wire logic            wb_stb_i,
    output logic                 wb_ack_o,
    output uart_pkg::word_t      wb_dat_o,

    input  wire logic            tx_busy_i,
    input  wire logic            rx_valid_i,
    input  wire uart_pkg::byte_t rx_data_i,

    output uart_pkg::word_t      divider_o,
    output logic                 enable_o,
    output logic                 div_changed_o,
    output logic                 tx_start_o,
    output uart_pkg::byte_t      tx_data_o,
    output logic                 rx_read_o
);

    uart_pkg::reg_sel_e reg_sel;
    logic               valid;
    logic               dat_stall;  // Data write held off by the transmitter
    logic               wr_ack;

    assign valid = wb_cyc_i && wb_stb_i;

    // Full address compare, the base has a clear low byte
    always_comb begin
        reg_sel = uart_pkg::SEL_NONE;
        if (valid) begin
            if (wb_adr_i == (BASE_ADR | uart_pkg::DIV_OFS))
                reg_sel = uart_pkg::SEL_DIV;
            else if (wb_adr_i == (BASE_ADR | uart_pkg::DAT_OFS))
                reg_sel = uart_pkg::SEL_DAT;
            else if (wb_adr_i == (BASE_ADR | uart_pkg::CFG_OFS))
                reg_sel = uart_pkg::SEL_CFG;
        end
    end

    assign dat_stall = (reg_sel == uart_pkg::SEL_DAT) && wb_we_i && tx_busy_i;
    assign wb_ack_o  = (reg_sel != uart_pkg::SEL_NONE) && !dat_stall;
    assign wr_ack    = wb_ack_o && wb_we_i;

    // Strobes towards the datapath
    assign tx_start_o    = wr_ack && (reg_sel == uart_pkg::SEL_DAT) && wb_sel_i[0];
    assign tx_data_o     = wb_dat_i[7:0];
    assign rx_read_o     = wb_ack_o && !wb_we_i && (reg_sel == uart_pkg::SEL_DAT);
    assign div_changed_o = wr_ack && (reg_sel == uart_pkg::SEL_DIV) && (|wb_sel_i)
                           && enable_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            divider_o <= 32'd1;
            enable_o  <= 1'b0;
        end else begin
            if (wr_ack && reg_sel == uart_pkg::SEL_DIV) begin
                for (int i = 0; i < 4; i++) begin
                    if (wb_sel_i[i])
                        divider_o[i*8 +: 8] <= wb_dat_i[i*8 +: 8];
                end
            end
            if (wr_ack && reg_sel == uart_pkg::SEL_CFG && wb_sel_i[0])
                enable_o <= wb_dat_i[0];  // Bit 0 only
        end
    end

    // Read data
    always_comb begin
        case (reg_sel)
            uart_pkg::SEL_DIV: wb_dat_o = divider_o;
            uart_pkg::SEL_CFG: wb_dat_o = {31'd0, enable_o};
            uart_pkg::SEL_DAT: begin
                if (rx_valid_i)
                    wb_dat_o = {24'd0, rx_data_i};
                else
                    wb_dat_o = '1;  // Nothing waiting
            end
            default:           wb_dat_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Bus word and serial payload
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Register offsets from the base address
    localparam word_t DIV_OFS = 32'h0000_0000;
    localparam word_t DAT_OFS = 32'h0000_0004;
    localparam word_t CFG_OFS = 32'h0000_0008;

    // Idle bit times sent after reset or a divider change
    localparam int unsigned GUARD_BITS = 15;

    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_DIV,
        SEL_DAT,
        SEL_CFG
    } reg_sel_e;

    typedef enum logic [1:0] {
        RX_IDLE,   // Waiting for falling edge
        RX_START,  // Half bit to the start bit centre
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

`default_nettype wire
